// ==== all.f ====
ioq_entry_pkg.sv
ioq_ctrl_pkg.sv
ioq_entry_capture.sv
ioq_queue.sv
ioq_entry_issue.sv
nvme_ioq.sv
nvme_ioq_checker.sv
tb_nvme_ioq.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the NVMe I/O queue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_nvme_ioq \
  -f all.f \
  -o tb_nvme_ioq

status=0
output=$(./obj_dir/tb_nvme_ioq 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -qx "Regression passed" <<< "$output"; then
  exit 0
fi
echo "run.sh: simulation did not pass" >&2
exit 1

// ==== tb_nvme_ioq.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_nvme_ioq
  import ioq_entry_pkg::*;
();

  localparam int CLK_PERIOD      = 10;
  localparam int NUM_MAIN        = 24;
  localparam int NUM_BP          = 8;
  localparam int NUM_ROWS        = NUM_MAIN + NUM_BP;
  localparam int WATCHDOG_CYCLES = 40 * NUM_ROWS + 200;
  // 4 queued, 1 in the output register, 1 in capture
  localparam int MAX_IN_FLIGHT   = 6;

  // One row is either a CSR command or a PCIe completion
  typedef struct packed {
    logic        is_cpl;
    csr_word_t   cmd;
    ioq_data_t   data;
    byte_en_t    be;
    cpl_tag_t    tag;
    logic        poison;
    cpl_err_t    err;
    cpl_status_t status;
  } stim_row_t;

  logic        user_clk;
  logic        user_reset;
  logic        user_lnk_up;
  logic        csr_ioq_valid;
  csr_word_t   csr_ioq_data;
  logic        sq_ready;
  logic        ioq_rq_valid;
  req_type_t   ioq_rq_req_type;
  req_addr_t   ioq_rq_addr;
  ioq_data_t   ioq_rq_data;
  byte_en_t    ioq_rq_byte_en;
  dword_cnt_t  ioq_rq_dword;
  req_tag_t    ioq_rq_tag;
  logic        rq_ioq_ack;
  logic        rc_ioq_valid;
  ioq_data_t   rc_ioq_data;
  byte_en_t    rc_ioq_be;
  cpl_tag_t    rc_ioq_tag;
  logic        rc_ioq_poison;
  cpl_err_t    rc_ioq_errcode;
  cpl_status_t rc_ioq_status;
  logic        cq_ready;
  logic        ioq_csr_valid;
  csr_word_t   ioq_csr_data;
  logic        csr_ioq_ack;

  stim_row_t   stim_table [NUM_ROWS];
  csr_word_t   sq_expect [$];
  csr_word_t   cq_expect [$];
  logic [15:0] lfsr;
  logic        rq_hold;
  int          value_errors;
  int          flow_errors;
  int          rq_checked;
  int          csr_checked;

  nvme_ioq #(.QUEUE_DEPTH_LOG2(2)) dut (
    .user_clk       (user_clk),
    .user_reset     (user_reset),
    .user_lnk_up    (user_lnk_up),
    .csr_ioq_valid  (csr_ioq_valid),
    .csr_ioq_data   (csr_ioq_data),
    .sq_ready       (sq_ready),
    .ioq_rq_valid   (ioq_rq_valid),
    .ioq_rq_req_type(ioq_rq_req_type),
    .ioq_rq_addr    (ioq_rq_addr),
    .ioq_rq_data    (ioq_rq_data),
    .ioq_rq_byte_en (ioq_rq_byte_en),
    .ioq_rq_dword   (ioq_rq_dword),
    .ioq_rq_tag     (ioq_rq_tag),
    .rq_ioq_ack     (rq_ioq_ack),
    .rc_ioq_valid   (rc_ioq_valid),
    .rc_ioq_data    (rc_ioq_data),
    .rc_ioq_be      (rc_ioq_be),
    .rc_ioq_tag     (rc_ioq_tag),
    .rc_ioq_poison  (rc_ioq_poison),
    .rc_ioq_errcode (rc_ioq_errcode),
    .rc_ioq_status  (rc_ioq_status),
    .cq_ready       (cq_ready),
    .ioq_csr_valid  (ioq_csr_valid),
    .ioq_csr_data   (ioq_csr_data),
    .csr_ioq_ack    (csr_ioq_ack)
  );

  always #(CLK_PERIOD / 2) user_clk = ~user_clk;

  // --------------------
  // Random source
  // --------------------

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic take_bit();
    lfsr = lfsr_next(lfsr);
    return lfsr[0];
  endfunction

  function automatic csr_word_t rand_word();
    csr_word_t w;
    for (int i = 0; i < 256; i++) begin
      w[i] = take_bit();
    end
    return w;
  endfunction

  // Response layout: data, byte enables, tag, poison, error, status, zero fill
  function automatic csr_word_t response_word(input stim_row_t row);
    return {104'b0, row.status, row.err, row.poison, row.tag, row.be, row.data};
  endfunction

  // --------------------
  // Stimulus
  // --------------------

  task automatic apply_row(input stim_row_t row, input int max_wait, output logic accepted);
    int waited;
    accepted = 1'b0;
    waited   = 0;
    if (row.is_cpl) begin
      rc_ioq_valid   = 1'b1;
      rc_ioq_data    = row.data;
      rc_ioq_be      = row.be;
      rc_ioq_tag     = row.tag;
      rc_ioq_poison  = row.poison;
      rc_ioq_errcode = row.err;
      rc_ioq_status  = row.status;
    end else begin
      csr_ioq_valid = 1'b1;
      csr_ioq_data  = row.cmd;
    end
    while (!accepted && waited < max_wait) begin
      @(negedge user_clk);
      if (row.is_cpl ? cq_ready : sq_ready) begin
        accepted = 1'b1;
      end
      @(posedge user_clk);
      #1;
      waited++;
    end
    csr_ioq_valid = 1'b0;
    rc_ioq_valid  = 1'b0;
    if (accepted && row.is_cpl) begin
      cq_expect.push_back(response_word(row));
    end else if (accepted) begin
      sq_expect.push_back(row.cmd);
    end
  endtask

  task automatic wait_drain();
    while (sq_expect.size() != 0 || cq_expect.size() != 0) begin
      @(negedge user_clk);
    end
    @(posedge user_clk);
    #1;
  endtask

  task automatic print_summary();
    $display("Summary: %0d value errors, %0d flow errors, %0d requests and %0d responses checked",
             value_errors, flow_errors, rq_checked, csr_checked);
  endtask

  // Random acknowledge on both outputs, request side can be held off
  always @(posedge user_clk) begin
    #1;
    rq_ioq_ack  = !rq_hold && take_bit();
    csr_ioq_ack = take_bit();
  end

  // --------------------
  // Output monitors
  // --------------------

  always @(negedge user_clk) begin : request_monitor
    csr_word_t    exp;
    logic [220:0] got;
    logic [220:0] want;
    if (!user_reset && ioq_rq_valid && rq_ioq_ack) begin
      if (sq_expect.size() == 0) begin
        flow_errors++;
        $display("Request issued at %0t with no command outstanding", $time);
      end else begin
        exp  = sq_expect.pop_front();
        got  = {ioq_rq_tag, ioq_rq_dword, ioq_rq_byte_en, ioq_rq_data, ioq_rq_addr,
                ioq_rq_req_type};
        want = {exp[220:215], exp[214:204], exp[203:196], exp[195:68], exp[67:4], exp[3:0]};
        if (got !== want) begin
          value_errors++;
          $display("Error at %0t: request got %h expected %h", $time, got, want);
        end
        rq_checked++;
      end
    end
  end

  always @(negedge user_clk) begin : response_monitor
    csr_word_t exp;
    if (!user_reset && ioq_csr_valid && csr_ioq_ack) begin
      if (cq_expect.size() == 0) begin
        flow_errors++;
        $display("Response issued at %0t with no completion outstanding", $time);
      end else begin
        exp = cq_expect.pop_front();
        if (ioq_csr_data !== exp) begin
          value_errors++;
          $display("Error at %0t: response got %h expected %h", $time, ioq_csr_data, exp);
        end
        csr_checked++;
      end
    end
  end

  initial begin : watchdog
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("Timeout after %0d cycles, outputs never drained", WATCHDOG_CYCLES);
    print_summary();
    $display("Regression failed");
    $finish;
  end

  // --------------------
  // Test sequence
  // --------------------

  initial begin : main_sequence
    int   accepted_count;
    int   row_idx;
    logic ok;
    csr_word_t r;
    user_clk = 1'b0;
    user_reset = 1'b1;
    // Link up while in reset, ready must still stay low
    user_lnk_up = 1'b1;
    csr_ioq_valid = 1'b0;
    csr_ioq_data = '0;
    rq_ioq_ack = 1'b0;
    rc_ioq_valid = 1'b0;
    rc_ioq_data = '0;
    rc_ioq_be = '0;
    rc_ioq_tag = '0;
    rc_ioq_poison = 1'b0;
    rc_ioq_errcode = '0;
    rc_ioq_status = '0;
    csr_ioq_ack = 1'b0;
    rq_hold = 1'b0;
    lfsr = 16'd51;
    value_errors = 0;
    flow_errors = 0;
    rq_checked = 0;
    csr_checked = 0;
    // Back-pressure rows at the end are all submissions
    for (int i = 0; i < NUM_ROWS; i++) begin
      stim_table[i].is_cpl = (i < NUM_MAIN) ? take_bit() : 1'b0;
      stim_table[i].cmd = rand_word();
      r = rand_word();
      stim_table[i].data = r[127:0];
      stim_table[i].be = r[135:128];
      stim_table[i].tag = r[143:136];
      stim_table[i].poison = r[144];
      stim_table[i].err = r[148:145];
      stim_table[i].status = r[151:149];
    end
    repeat (3) begin
      @(posedge user_clk);
      #1;
      if (sq_ready || cq_ready || ioq_rq_valid || ioq_csr_valid) begin
        value_errors++;
        $display("Error at %0t: ready or valid high during reset", $time);
      end
    end
    user_reset = 1'b0;
    user_lnk_up = 1'b0;
    // Link down, offers must be ignored
    csr_ioq_valid = 1'b1;
    rc_ioq_valid = 1'b1;
    repeat (10) begin
      @(negedge user_clk);
      if (sq_ready || cq_ready || ioq_rq_valid || ioq_csr_valid) begin
        value_errors++;
        $display("Error at %0t: ready or valid high with the link down", $time);
      end
    end
    @(posedge user_clk);
    #1;
    csr_ioq_valid = 1'b0;
    rc_ioq_valid = 1'b0;
    user_lnk_up = 1'b1;
    for (int i = 0; i < NUM_MAIN; i++) begin
      apply_row(stim_table[i], 40, ok);
      if (!ok) begin
        flow_errors++;
        $display("Row %0d was not accepted within 40 cycles", i);
      end
    end
    wait_drain();
    // Request ack held low until the submission path fills up
    @(negedge user_clk);
    rq_hold = 1'b1;
    @(posedge user_clk);
    #1;
    accepted_count = 0;
    row_idx = NUM_MAIN;
    ok = 1'b1;
    while (ok && row_idx < NUM_ROWS) begin
      apply_row(stim_table[row_idx], 12, ok);
      if (ok) begin
        accepted_count++;
        row_idx++;
      end
    end
    if (accepted_count > MAX_IN_FLIGHT || sq_ready) begin
      flow_errors++;
      $display("sq_ready still high after %0d commands with ack held low", accepted_count);
    end
    @(negedge user_clk);
    rq_hold = 1'b0;
    @(posedge user_clk);
    #1;
    while (row_idx < NUM_ROWS) begin
      apply_row(stim_table[row_idx], 40, ok);
      if (!ok) begin
        flow_errors++;
        $display("Row %0d was not accepted after ack returned", row_idx);
      end
      row_idx++;
    end
    wait_drain();
    print_summary();
    if (value_errors == 0 && flow_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== nvme_ioq_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module nvme_ioq_checker #(
  parameter int ENTRY_WIDTH = 32
) (
  input logic                   user_clk,
  input logic                   user_reset,
  input logic                   out_valid,
  input logic [ENTRY_WIDTH-1:0] out_entry,
  input logic                   out_ack
);

  // --------------------
  // Output handshake
  // --------------------

  // An offered entry waits for its acknowledge
  valid_held: assert property (
    @(posedge user_clk) disable iff (user_reset)
    out_valid && !out_ack |=> out_valid
  ) else $error("out_valid dropped without an acknowledge");

  entry_stable: assert property (
    @(posedge user_clk) disable iff (user_reset)
    out_valid && !out_ack |=> $stable(out_entry)
  ) else $error("out_entry changed while waiting for an acknowledge");

  // Nothing offered while in reset
  valid_low_in_reset: assert property (
    @(posedge user_clk) user_reset |-> !out_valid
  ) else $error("out_valid high during reset");

endmodule

// One checker per output register, request and response paths
bind ioq_entry_issue nvme_ioq_checker #(.ENTRY_WIDTH(ENTRY_WIDTH)) issue_checker (
  .user_clk  (user_clk),
  .user_reset(user_reset),
  .out_valid (out_valid),
  .out_entry (out_entry),
  .out_ack   (out_ack)
);

`default_nettype wire

// ==== nvme_ioq.sv ====
`timescale 1ns/1ps
`default_nettype none

module nvme_ioq
  import ioq_entry_pkg::*;
  import ioq_ctrl_pkg::*;
#(
  parameter int QUEUE_DEPTH_LOG2 = DEFAULT_QUEUE_DEPTH_LOG2
) (
  input  logic        user_clk,
  input  logic        user_reset,
  input  logic        user_lnk_up,

  // CSR command in
  input  logic        csr_ioq_valid,
  input  csr_word_t   csr_ioq_data,
  output logic        sq_ready,

  // PCIe request out
  output logic        ioq_rq_valid,
  output req_type_t   ioq_rq_req_type,
  output req_addr_t   ioq_rq_addr,
  output ioq_data_t   ioq_rq_data,
  output byte_en_t    ioq_rq_byte_en,
  output dword_cnt_t  ioq_rq_dword,
  output req_tag_t    ioq_rq_tag,
  input  logic        rq_ioq_ack,

  // PCIe completion in
  input  logic        rc_ioq_valid,
  input  ioq_data_t   rc_ioq_data,
  input  byte_en_t    rc_ioq_be,
  input  cpl_tag_t    rc_ioq_tag,
  input  logic        rc_ioq_poison,
  input  cpl_err_t    rc_ioq_errcode,
  input  cpl_status_t rc_ioq_status,
  output logic        cq_ready,

  // CSR response out
  output logic        ioq_csr_valid,
  output csr_word_t   ioq_csr_data,
  input  logic        csr_ioq_ack
);

  localparam int SQ_ENTRY_WIDTH = $bits(sq_entry_t);
  localparam int CQ_ENTRY_WIDTH = $bits(cq_entry_t);

  // --------------------
  // Submission path
  // --------------------

  sq_entry_t sq_in_entry;
  sq_entry_t sq_wr_entry;
  sq_entry_t sq_head_entry;
  sq_entry_t sq_out_entry;
  logic      sq_write;
  logic      sq_full;
  logic      sq_head_valid;
  logic      sq_pop;

  // Upper command bits carry nothing
  assign sq_in_entry = csr_ioq_data[SQ_ENTRY_WIDTH-1:0];

  ioq_entry_capture #(.ENTRY_WIDTH(SQ_ENTRY_WIDTH)) sq_capture (
    .user_clk   (user_clk),
    .user_reset (user_reset),
    .link_up    (user_lnk_up),
    .in_valid   (csr_ioq_valid),
    .in_entry   (sq_in_entry),
    .ready      (sq_ready),
    .queue_full (sq_full),
    .queue_write(sq_write),
    .queue_entry(sq_wr_entry)
  );

  ioq_queue #(
    .ENTRY_WIDTH     (SQ_ENTRY_WIDTH),
    .QUEUE_DEPTH_LOG2(QUEUE_DEPTH_LOG2)
  ) sq_queue (
    .user_clk   (user_clk),
    .user_reset (user_reset),
    .write      (sq_write),
    .write_entry(sq_wr_entry),
    .full       (sq_full),
    .pop        (sq_pop),
    .head_entry (sq_head_entry),
    .head_valid (sq_head_valid)
  );

  ioq_entry_issue #(.ENTRY_WIDTH(SQ_ENTRY_WIDTH)) sq_issue (
    .user_clk  (user_clk),
    .user_reset(user_reset),
    .head_valid(sq_head_valid),
    .head_entry(sq_head_entry),
    .pop       (sq_pop),
    .out_valid (ioq_rq_valid),
    .out_entry (sq_out_entry),
    .out_ack   (rq_ioq_ack)
  );

  assign ioq_rq_req_type = sq_out_entry.req_type;
  assign ioq_rq_addr     = sq_out_entry.addr;
  assign ioq_rq_data     = sq_out_entry.data;
  assign ioq_rq_byte_en  = sq_out_entry.byte_en;
  assign ioq_rq_dword    = sq_out_entry.dword_cnt;
  assign ioq_rq_tag      = sq_out_entry.tag;

  // --------------------
  // Completion path
  // --------------------

  cq_entry_t cq_in_entry;
  cq_entry_t cq_wr_entry;
  cq_entry_t cq_head_entry;
  cq_entry_t cq_out_entry;
  logic      cq_write;
  logic      cq_full;
  logic      cq_head_valid;
  logic      cq_pop;

  assign cq_in_entry.data     = rc_ioq_data;
  assign cq_in_entry.byte_en  = rc_ioq_be;
  assign cq_in_entry.tag      = rc_ioq_tag;
  assign cq_in_entry.poison   = rc_ioq_poison;
  assign cq_in_entry.err_code = rc_ioq_errcode;
  assign cq_in_entry.status   = rc_ioq_status;

  ioq_entry_capture #(.ENTRY_WIDTH(CQ_ENTRY_WIDTH)) cq_capture (
    .user_clk   (user_clk),
    .user_reset (user_reset),
    .link_up    (user_lnk_up),
    .in_valid   (rc_ioq_valid),
    .in_entry   (cq_in_entry),
    .ready      (cq_ready),
    .queue_full (cq_full),
    .queue_write(cq_write),
    .queue_entry(cq_wr_entry)
  );

  ioq_queue #(
    .ENTRY_WIDTH     (CQ_ENTRY_WIDTH),
    .QUEUE_DEPTH_LOG2(QUEUE_DEPTH_LOG2)
  ) cq_queue (
    .user_clk   (user_clk),
    .user_reset (user_reset),
    .write      (cq_write),
    .write_entry(cq_wr_entry),
    .full       (cq_full),
    .pop        (cq_pop),
    .head_entry (cq_head_entry),
    .head_valid (cq_head_valid)
  );

  ioq_entry_issue #(.ENTRY_WIDTH(CQ_ENTRY_WIDTH)) cq_issue (
    .user_clk  (user_clk),
    .user_reset(user_reset),
    .head_valid(cq_head_valid),
    .head_entry(cq_head_entry),
    .pop       (cq_pop),
    .out_valid (ioq_csr_valid),
    .out_entry (cq_out_entry),
    .out_ack   (csr_ioq_ack)
  );

  // Response word is the entry with zero fill above bit 151
  assign ioq_csr_data = {{($bits(csr_word_t) - CQ_ENTRY_WIDTH){1'b0}}, cq_out_entry};

endmodule

`default_nettype wire

// ==== ioq_entry_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module ioq_entry_issue
  import ioq_ctrl_pkg::*;
#(
  parameter int ENTRY_WIDTH = 32
) (
  input  logic                   user_clk,
  input  logic                   user_reset,

  input  logic                   head_valid,
  input  logic [ENTRY_WIDTH-1:0] head_entry,
  output logic                   pop,

  output logic                   out_valid,
  output logic [ENTRY_WIDTH-1:0] out_entry,
  input  logic                   out_ack
);

  issue_state_t           state_q;
  issue_state_t           state_d;
  logic                   load;
  logic [ENTRY_WIDTH-1:0] entry_q;

  // Reload when the register is free or being released this edge
  assign load = head_valid && ((state_q == EMPTY) || out_ack);
  assign pop  = load;

  assign out_valid = (state_q == HOLD);
  assign out_entry = entry_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      EMPTY: begin
        if (head_valid) begin
          state_d = HOLD;
        end
      end
      HOLD: begin
        // Back to back when the queue has the next entry ready
        if (out_ack && !head_valid) begin
          state_d = EMPTY;
        end
      end
      default: state_d = EMPTY;
    endcase
  end

  always_ff @(posedge user_clk or posedge user_reset) begin
    if (user_reset) begin
      state_q <= EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // Output payload only changes on a load
  always_ff @(posedge user_clk) begin
    if (load) begin
      entry_q <= head_entry;
    end
  end

endmodule

`default_nettype wire

// ==== ioq_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module ioq_queue #(
  parameter int ENTRY_WIDTH      = 32,
  parameter int QUEUE_DEPTH_LOG2 = 4
) (
  input  logic                   user_clk,
  input  logic                   user_reset,

  input  logic                   write,
  input  logic [ENTRY_WIDTH-1:0] write_entry,
  output logic                   full,

  input  logic                   pop,
  output logic [ENTRY_WIDTH-1:0] head_entry,
  output logic                   head_valid
);

  localparam int DEPTH = 1 << QUEUE_DEPTH_LOG2;

  // Extra MSB tells a full queue from an empty one
  typedef logic [QUEUE_DEPTH_LOG2:0]   ptr_t;
  typedef logic [QUEUE_DEPTH_LOG2-1:0] addr_t;

  logic [ENTRY_WIDTH-1:0] mem [DEPTH];

  ptr_t  wr_ptr_q;
  ptr_t  rd_ptr_q;
  addr_t wr_addr;
  addr_t rd_addr;
  logic  do_write;
  logic  do_pop;

  assign wr_addr = wr_ptr_q[QUEUE_DEPTH_LOG2-1:0];
  assign rd_addr = rd_ptr_q[QUEUE_DEPTH_LOG2-1:0];

  // --------------------
  // Status flags
  // --------------------

  assign head_valid = (wr_ptr_q != rd_ptr_q);

  // Same slot, opposite wrap bit
  assign full = (wr_addr == rd_addr) &&
                (wr_ptr_q[QUEUE_DEPTH_LOG2] != rd_ptr_q[QUEUE_DEPTH_LOG2]);

  // Overflow and underflow requests are dropped
  assign do_write = write && !full;
  assign do_pop   = pop && head_valid;

  // --------------------
  // Pointers
  // --------------------

  always_ff @(posedge user_clk or posedge user_reset) begin
    if (user_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end
    end
  end

  // --------------------
  // Storage
  // --------------------

  always_ff @(posedge user_clk) begin
    if (do_write) begin
      mem[wr_addr] <= write_entry;
    end
  end

  // Head is shown as soon as it is written
  assign head_entry = mem[rd_addr];

endmodule

`default_nettype wire

// ==== ioq_entry_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module ioq_entry_capture
  import ioq_ctrl_pkg::*;
#(
  parameter int ENTRY_WIDTH = 32
) (
  input  logic                   user_clk,
  input  logic                   user_reset,
  input  logic                   link_up,

  input  logic                   in_valid,
  input  logic [ENTRY_WIDTH-1:0] in_entry,
  output logic                   ready,

  input  logic                   queue_full,
  output logic                   queue_write,
  output logic [ENTRY_WIDTH-1:0] queue_entry
);

  capture_state_t         state_q;
  capture_state_t         state_d;
  logic                   open_q;
  logic                   accept;
  logic [ENTRY_WIDTH-1:0] entry_q;

  // Input stays closed until the first edge after reset release
  assign ready  = open_q && (state_q == IDLE) && link_up;
  assign accept = in_valid && ready;

  // Queue write waits for room
  assign queue_write = (state_q == WRITE) && !queue_full;
  assign queue_entry = entry_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = WRITE;
        end
      end
      WRITE: begin
        if (!queue_full) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge user_clk or posedge user_reset) begin
    if (user_reset) begin
      state_q <= IDLE;
      open_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      open_q  <= 1'b1;
    end
  end

  // Payload register
  always_ff @(posedge user_clk) begin
    if (accept) begin
      entry_q <= in_entry;
    end
  end

endmodule

`default_nettype wire

// ==== ioq_ctrl_pkg.sv ====
`default_nettype none

package ioq_ctrl_pkg;

  // --------------------
  // FSM states
  // --------------------

  // Input side, one entry held between accept and queue write
  typedef enum logic {
    IDLE,
    WRITE
  } capture_state_t;

  // Output side, whether the output register holds an entry
  typedef enum logic {
    EMPTY,
    HOLD
  } issue_state_t;

  // 16 entries per queue unless the top level overrides it
  localparam int DEFAULT_QUEUE_DEPTH_LOG2 = 4;

endpackage

`default_nettype wire

// ==== ioq_entry_pkg.sv ====
`default_nettype none

package ioq_entry_pkg;

  // --------------------
  // Field widths
  // --------------------

  typedef logic [3:0]   req_type_t;
  // Address type sits in the low bits of the address
  typedef logic [63:0]  req_addr_t;
  typedef logic [127:0] ioq_data_t;
  // First byte enable in [3:0], last byte enable in [7:4]
  typedef logic [7:0]   byte_en_t;
  typedef logic [10:0]  dword_cnt_t;
  typedef logic [5:0]   req_tag_t;
  typedef logic [7:0]   cpl_tag_t;
  typedef logic [3:0]   cpl_err_t;
  typedef logic [2:0]   cpl_status_t;
  typedef logic [255:0] csr_word_t;

  // --------------------
  // Queue entries
  // --------------------

  // Submission entry, LSB first is type, addr, data, byte_en, dword_cnt, tag
  // Same order as the CSR command word, bits 255:221 of that word are ignored
  typedef struct packed {
    req_tag_t   tag;
    dword_cnt_t dword_cnt;
    byte_en_t   byte_en;
    ioq_data_t  data;
    req_addr_t  addr;
    req_type_t  req_type;
  } sq_entry_t;

  // Completion entry, same order as the CSR response word
  // data 127:0, byte_en 135:128, tag 143:136, poison 144
  // err_code 148:145, status 151:149, zero fill above
  typedef struct packed {
    cpl_status_t status;
    cpl_err_t    err_code;
    logic        poison;
    cpl_tag_t    tag;
    byte_en_t    byte_en;
    ioq_data_t   data;
  } cq_entry_t;

endpackage

`default_nettype wire
